//--- Bender.yml
package:
  name: exec_stage

sources:
  - files:
      - logic/exec_pkg.sv
      - logic/dx_if.sv
      - logic/xw_if.sv
      - logic/exec_issue_queue.sv
      - logic/exec_alu.sv
      - logic/exec_mul_pipe.sv
      - logic/exec_wb_arbiter.sv
      - logic/exec_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/exec_tb.sv

//--- logic/dx_if.sv
//----------------------------------------
// Issue channel, one operation toward an
// execution unit with valid/ready flow
//----------------------------------------

`default_nettype none

interface dx_if;
  import exec_pkg::*;

  logic                     val;     // Operation present
  logic                     rdy;     // Unit can take it
  logic [seq_bits-1:0]      seq_num; // Issue order tag
  logic [xlen-1:0]          op1;
  logic [xlen-1:0]          op2;
  logic [reg_addr_bits-1:0] waddr;   // Destination register
  exec_uop_e                uop;

  // Issuer holds fields stable while val && !rdy
  modport issuer (
    output val, seq_num, op1, op2, waddr, uop,
    input  rdy
  );

  modport unit (
    input  val, seq_num, op1, op2, waddr, uop,
    output rdy
  );

endinterface

`default_nettype wire

//--- logic/exec_alu.sv
//----------------------------------------
// Single-cycle ALU. Result is registered
// with its tag and handed to writeback.
//----------------------------------------

`default_nettype none

module exec_alu (
  input  logic clk,
  input  logic rst,
  dx_if.unit   in_port,
  xw_if.unit   out_port
);
  import exec_pkg::*;

  logic                     r_val;
  logic [seq_bits-1:0]      r_seq;
  logic [reg_addr_bits-1:0] r_waddr;
  logic [xlen-1:0]          r_wdata;

  logic            in_xfer;
  logic            out_xfer;
  logic [xlen-1:0] alu_result;

  // Accept when result reg empty or draining now
  assign in_port.rdy = ~r_val | out_port.rdy;
  assign in_xfer     = in_port.val & in_port.rdy;
  assign out_xfer    = r_val & out_port.rdy;

  //----------------------------------------
  // Datapath
  //----------------------------------------

  always_comb begin
    case (in_port.uop)
      OP_ADD:  alu_result = in_port.op1 + in_port.op2;
      OP_SUB:  alu_result = in_port.op1 - in_port.op2;
      OP_AND:  alu_result = in_port.op1 & in_port.op2;
      OP_OR:   alu_result = in_port.op1 | in_port.op2;
      OP_XOR:  alu_result = in_port.op1 ^ in_port.op2;
      OP_SLL:  alu_result = in_port.op1 << in_port.op2[shamt_bits-1:0];
      OP_SRL:  alu_result = in_port.op1 >> in_port.op2[shamt_bits-1:0];
      OP_SLT: begin
        // Signed compare, zero-extended flag
        alu_result = {{(xlen-1){1'b0}}, ($signed(in_port.op1) < $signed(in_port.op2))};
      end
      default: alu_result = '0;  // Mul ops never reach here
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      r_val <= 1'b0;
    end else if (in_xfer) begin
      r_val <= 1'b1;
    end else if (out_xfer) begin
      r_val <= 1'b0;   // Drained, nothing new
    end
  end

  // Payload only, val qualifies it
  always_ff @(posedge clk) begin
    if (in_xfer) begin
      r_seq   <= in_port.seq_num;
      r_waddr <= in_port.waddr;
      r_wdata <= alu_result;
    end
  end

  assign out_port.val     = r_val;
  assign out_port.seq_num = r_seq;
  assign out_port.waddr   = r_waddr;
  assign out_port.wdata   = r_wdata;

  // Queue steering keeps multiplies away
  a_no_mul_op: assert property (@(posedge clk) disable iff (rst)
    in_port.val |-> !is_mul_op(in_port.uop));

endmodule

`default_nettype wire

//--- logic/exec_issue_queue.sv
//----------------------------------------
// Two-entry issue FIFO. The head goes to
// the ALU or the multiplier by its class.
//----------------------------------------

`default_nettype none

module exec_issue_queue (
  input  logic clk,
  input  logic rst,
  dx_if.unit   in_port,
  dx_if.issuer alu_port,
  dx_if.issuer mul_port
);
  import exec_pkg::*;

  // Entry storage, no reset
  logic [seq_bits-1:0]      q_seq   [0:1];
  logic [xlen-1:0]          q_op1   [0:1];
  logic [xlen-1:0]          q_op2   [0:1];
  logic [reg_addr_bits-1:0] q_waddr [0:1];
  exec_uop_e                q_uop   [0:1];

  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;  // 0..2 entries held
  logic       push;
  logic       pop;
  logic       head_val;
  logic       head_mul;

  assign in_port.rdy = (count != 2'd2); // Not full
  assign push        = in_port.val & in_port.rdy;
  assign pop         = (alu_port.val & alu_port.rdy) | (mul_port.val & mul_port.rdy);

  assign head_val = (count != 2'd0);
  assign head_mul = is_mul_op(q_uop[rd_ptr]);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop)  rd_ptr <= ~rd_ptr;
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;       // Idle or push+pop
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_seq[wr_ptr]   <= in_port.seq_num;
      q_op1[wr_ptr]   <= in_port.op1;
      q_op2[wr_ptr]   <= in_port.op2;
      q_waddr[wr_ptr] <= in_port.waddr;
      q_uop[wr_ptr]   <= in_port.uop;
    end
  end

  //----------------------------------------
  // Head steering
  //----------------------------------------

  assign alu_port.val     = head_val & ~head_mul; // Only one side sees val
  assign alu_port.seq_num = q_seq[rd_ptr];
  assign alu_port.op1     = q_op1[rd_ptr];
  assign alu_port.op2     = q_op2[rd_ptr];
  assign alu_port.waddr   = q_waddr[rd_ptr];
  assign alu_port.uop     = q_uop[rd_ptr];

  assign mul_port.val     = head_val & head_mul;
  assign mul_port.seq_num = q_seq[rd_ptr];
  assign mul_port.op1     = q_op1[rd_ptr];
  assign mul_port.op2     = q_op2[rd_ptr];
  assign mul_port.waddr   = q_waddr[rd_ptr];
  assign mul_port.uop     = q_uop[rd_ptr];

  // Count and pointers stay in step, an overrun breaks this
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    (count <= 2'd2) && ((count == 2'd1) == (wr_ptr != rd_ptr)));

  // Stalled head stays on its own port with the same tag
  a_alu_head_hold: assert property (@(posedge clk) disable iff (rst)
    (alu_port.val && !alu_port.rdy) |=>
      (alu_port.val && !mul_port.val && $stable(alu_port.seq_num)));

  a_mul_head_hold: assert property (@(posedge clk) disable iff (rst)
    (mul_port.val && !mul_port.rdy) |=>
      (mul_port.val && !alu_port.val && $stable(mul_port.seq_num)));

endmodule

`default_nettype wire

//--- logic/exec_mul_pipe.sv
//----------------------------------------
// Pipelined multiplier. Input register,
// product stage, then a stall-able chain.
// Latency is p_pipeline_stages cycles.
//----------------------------------------

`default_nettype none

module exec_mul_pipe #(
  parameter int p_pipeline_stages = exec_pkg::mul_stages
) (
  input  logic clk,
  input  logic rst,
  dx_if.unit   in_port,
  xw_if.unit   out_port
);
  import exec_pkg::*;

  //----------------------------------------
  // Input register
  //----------------------------------------

  logic                     in_val;
  logic [seq_bits-1:0]      in_seq;
  logic [reg_addr_bits-1:0] in_waddr;
  logic [xlen-1:0]          in_op1;
  logic [xlen-1:0]          in_op2;
  exec_uop_e                in_uop;
  logic                     in_xfer;

  logic signed [2*xlen-1:0] product;
  logic [xlen-1:0]          product_word;

  // Stage k holds a finished product word
  logic                     st_val   [1:p_pipeline_stages];
  logic [seq_bits-1:0]      st_seq   [1:p_pipeline_stages];
  logic [reg_addr_bits-1:0] st_waddr [1:p_pipeline_stages];
  logic [xlen-1:0]          st_wdata [1:p_pipeline_stages];
  logic                     st_rdy   [0:p_pipeline_stages]; // Stage k may hand off

  assign in_port.rdy = st_rdy[0] | ~in_val;
  assign in_xfer     = in_port.val & in_port.rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_val <= 1'b0;
    end else if (in_xfer) begin
      in_val <= 1'b1;
    end else if (in_val & st_rdy[0]) begin
      in_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      in_seq   <= in_port.seq_num;
      in_waddr <= in_port.waddr;
      in_op1   <= in_port.op1;
      in_op2   <= in_port.op2;
      in_uop   <= in_port.uop;
    end
  end

  // Low word is the same signed or unsigned
  assign product      = $signed(in_op1) * $signed(in_op2);
  assign product_word = (in_uop == OP_MULH) ? product[2*xlen-1:xlen] : product[xlen-1:0];

  //----------------------------------------
  // Stage chain
  //----------------------------------------

  assign st_rdy[p_pipeline_stages] = out_port.rdy;

  for (genvar k = 1; k <= p_pipeline_stages; k++) begin : g_stage
    logic prev_val;

    assign st_rdy[k-1] = st_rdy[k] | ~st_val[k]; // Room if empty or draining

    if (k == 1) begin : g_first
      assign prev_val = in_val;

      always_ff @(posedge clk) begin
        if (in_val & st_rdy[0]) begin
          st_seq[k]   <= in_seq;
          st_waddr[k] <= in_waddr;
          st_wdata[k] <= product_word;
        end
      end
    end else begin : g_next
      assign prev_val = st_val[k-1];

      always_ff @(posedge clk) begin
        if (st_val[k-1] & st_rdy[k-1]) begin
          st_seq[k]   <= st_seq[k-1];
          st_waddr[k] <= st_waddr[k-1];
          st_wdata[k] <= st_wdata[k-1];
        end
      end
    end

    always_ff @(posedge clk) begin
      if (rst) begin
        st_val[k] <= 1'b0;
      end else if (prev_val & st_rdy[k-1]) begin
        st_val[k] <= 1'b1;
      end else if (st_val[k] & st_rdy[k]) begin
        st_val[k] <= 1'b0;  // Moved on, bubble left
      end
    end
  end

  assign out_port.val     = st_val[p_pipeline_stages];
  assign out_port.seq_num = st_seq[p_pipeline_stages];
  assign out_port.waddr   = st_waddr[p_pipeline_stages];
  assign out_port.wdata   = st_wdata[p_pipeline_stages];

  // Stalled result must not slip or change
  a_hold: assert property (@(posedge clk) disable iff (rst)
    (out_port.val && !out_port.rdy) |=>
      (out_port.val && $stable(out_port.seq_num) &&
       $stable(out_port.waddr) && $stable(out_port.wdata)));

endmodule

`default_nettype wire

//--- logic/exec_pkg.sv
//----------------------------------------
// Shared widths, micro-op codes and unit
// latencies for the execute stage. Import
// into any block that needs them.
//----------------------------------------

`default_nettype none

package exec_pkg;

  //----------------------------------------
  // Widths
  //----------------------------------------

  localparam int xlen          = 32; // Operand and result word
  localparam int seq_bits      = 6;  // 64 ops in flight can be told apart
  localparam int reg_addr_bits = 5;  // Architectural destination
  localparam int shamt_bits    = 5;  // Shift amount, low bits of op2

  //----------------------------------------
  // Latencies
  //----------------------------------------

  // Multiplier stages after its input register
  localparam int mul_stages = 3;

  //----------------------------------------
  // Micro-ops
  //----------------------------------------

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLL  = 4'd5,
    OP_SRL  = 4'd6,
    OP_SLT  = 4'd7,  // Signed compare
    OP_MUL  = 4'd8,  // Low product word
    OP_MULH = 4'd9   // High word, signed x signed
  } exec_uop_e;

  // Operation class, steers the issue queue head
  function automatic logic is_mul_op(exec_uop_e uop);
    return (uop == OP_MUL) || (uop == OP_MULH);
  endfunction

endpackage

`default_nettype wire

//--- logic/exec_top.sv
//----------------------------------------
// Execute stage top. Issue queue, ALU,
// multiplier and writeback arbiter.
//----------------------------------------

`default_nettype none

module exec_top (
  input  logic                               clk,
  input  logic                               rst,

  // Issue port
  input  logic                               issue_val,
  output logic                               issue_rdy,
  input  logic [exec_pkg::seq_bits-1:0]      issue_seq_num,
  input  logic [exec_pkg::xlen-1:0]          issue_op1,
  input  logic [exec_pkg::xlen-1:0]          issue_op2,
  input  logic [exec_pkg::reg_addr_bits-1:0] issue_waddr,
  input  exec_pkg::exec_uop_e                issue_uop,

  // Writeback port
  output logic                               wb_val,
  input  logic                               wb_rdy,
  output logic [exec_pkg::seq_bits-1:0]      wb_seq_num,
  output logic [exec_pkg::reg_addr_bits-1:0] wb_waddr,
  output logic [exec_pkg::xlen-1:0]          wb_wdata
);

  dx_if issue_dx ();  // Plain ports into the queue
  dx_if alu_dx ();
  dx_if mul_dx ();
  xw_if alu_xw ();
  xw_if mul_xw ();

  assign issue_dx.val     = issue_val;
  assign issue_dx.seq_num = issue_seq_num;
  assign issue_dx.op1     = issue_op1;
  assign issue_dx.op2     = issue_op2;
  assign issue_dx.waddr   = issue_waddr;
  assign issue_dx.uop     = issue_uop;
  assign issue_rdy        = issue_dx.rdy;

  exec_issue_queue u_issue (
    .clk      (clk),
    .rst      (rst),
    .in_port  (issue_dx),
    .alu_port (alu_dx),
    .mul_port (mul_dx)
  );

  exec_alu u_alu (
    .clk      (clk),
    .rst      (rst),
    .in_port  (alu_dx),
    .out_port (alu_xw)
  );

  exec_mul_pipe #(
    .p_pipeline_stages (exec_pkg::mul_stages)
  ) u_mul (
    .clk      (clk),
    .rst      (rst),
    .in_port  (mul_dx),
    .out_port (mul_xw)
  );

  exec_wb_arbiter u_wb (
    .clk        (clk),
    .rst        (rst),
    .alu_res    (alu_xw),
    .mul_res    (mul_xw),
    .wb_val     (wb_val),
    .wb_seq_num (wb_seq_num),
    .wb_waddr   (wb_waddr),
    .wb_wdata   (wb_wdata),
    .wb_rdy     (wb_rdy)
  );

endmodule

`default_nettype wire

//--- logic/exec_wb_arbiter.sv
//----------------------------------------
// Round-robin merge of ALU and multiplier
// results onto the single writeback port
//----------------------------------------

`default_nettype none

module exec_wb_arbiter (
  input  logic                                clk,
  input  logic                                rst,
  xw_if.wb                                    alu_res,
  xw_if.wb                                    mul_res,
  output logic                                wb_val,
  output logic [exec_pkg::seq_bits-1:0]       wb_seq_num,
  output logic [exec_pkg::reg_addr_bits-1:0]  wb_waddr,
  output logic [exec_pkg::xlen-1:0]           wb_wdata,
  input  logic                                wb_rdy
);
  import exec_pkg::*;

  logic last_mul;   // Multiplier won the last transfer
  logic locked;     // Writeback stalled last cycle
  logic locked_mul; // Which source was stalled
  logic rr_mul;     // Fresh round-robin pick
  logic grant_mul;
  logic wb_xfer;

  // Both valid: the side not granted last wins
  assign rr_mul    = mul_res.val & (~alu_res.val | ~last_mul);
  // Keep a stalled grant so wb fields hold
  assign grant_mul = locked ? locked_mul : rr_mul;

  assign wb_val     = alu_res.val | mul_res.val;
  assign wb_seq_num = grant_mul ? mul_res.seq_num : alu_res.seq_num;
  assign wb_waddr   = grant_mul ? mul_res.waddr   : alu_res.waddr;
  assign wb_wdata   = grant_mul ? mul_res.wdata   : alu_res.wdata;
  assign wb_xfer    = wb_val & wb_rdy;

  // Loser sees rdy low and holds
  assign alu_res.rdy = wb_rdy & ~grant_mul;
  assign mul_res.rdy = wb_rdy & grant_mul;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_mul   <= 1'b0;
      locked     <= 1'b0;
      locked_mul <= 1'b0;
    end else begin
      if (wb_xfer) begin
        last_mul <= grant_mul;  // Pointer moves on transfer only
      end
      locked     <= wb_val & ~wb_rdy;
      locked_mul <= grant_mul;
    end
  end

  // Lock or round robin only ever picks a source holding a result
  a_grant_valid: assert property (@(posedge clk) disable iff (rst)
    wb_val |-> (grant_mul ? mul_res.val : alu_res.val));

endmodule

`default_nettype wire

//--- logic/xw_if.sv
//----------------------------------------
// Result channel, one writeback from a unit
// toward the writeback arbiter
//----------------------------------------

`default_nettype none

interface xw_if;
  import exec_pkg::*;

  logic                     val;
  logic                     rdy;     // Arbiter granted this source
  logic [seq_bits-1:0]      seq_num;
  logic [reg_addr_bits-1:0] waddr;
  logic [xlen-1:0]          wdata;

  modport unit (
    output val, seq_num, waddr, wdata,
    input  rdy
  );

  modport wb (
    input  val, seq_num, waddr, wdata,
    output rdy
  );

endinterface

`default_nettype wire

//--- verif/exec_model.svh
//----------------------------------------
// Reference model for the execute stage
// testbench. Included in the testbench module.
//----------------------------------------

`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

logic [31:0] lcg_state = 32'd22472;  // Fixed seed

// 32-bit LCG, upper half carries the better bits
function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state;
endfunction

function automatic int unsigned rand_below(int unsigned n);
  logic [31:0] r;
  r = lcg_next();
  return r[31:16] % n;
endfunction

// Expected writeback word, straight from the op definitions
function automatic logic [31:0] expected_wdata(exec_uop_e uop, logic [31:0] a,
                                               logic [31:0] b);
  logic signed [63:0] prod;
  prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
  case (uop)
    OP_ADD:  return a + b;
    OP_SUB:  return a - b;
    OP_AND:  return a & b;
    OP_OR:   return a | b;
    OP_XOR:  return a ^ b;
    OP_SLL:  return a << b[4:0];
    OP_SRL:  return a >> b[4:0];
    OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    OP_MUL:  return prod[31:0];
    OP_MULH: return prod[63:32];  // Signed x signed high word
    default: return 32'hxxxx_xxxx;
  endcase
endfunction

// Expected table, indexed by seq_num
logic [31:0] exp_wdata  [64];
logic [4:0]  exp_waddr  [64];
bit          exp_is_mul [64];
bit          pending    [64];  // Issued, not yet written back
logic [5:0]  alu_order  [$];   // Issue order per class
logic [5:0]  mul_order  [$];
int          outstanding = 0;

task automatic model_issue(logic [5:0] seq, exec_uop_e uop, logic [31:0] a,
                           logic [31:0] b, logic [4:0] waddr);
  exp_wdata[seq]  = expected_wdata(uop, a, b);
  exp_waddr[seq]  = waddr;
  exp_is_mul[seq] = is_mul_op(uop);
  pending[seq]    = 1'b1;
  outstanding++;
  if (is_mul_op(uop)) mul_order.push_back(seq);
  else alu_order.push_back(seq);
endtask

`endif

//--- verif/exec_tb.sv
//----------------------------------------
// Testbench for exec_top. Random issue and
// writeback stall pattern, checked against
// the included reference model.
//----------------------------------------

`default_nettype none

module exec_tb;
  import exec_pkg::*;

  `include "exec_model.svh"

  typedef enum int {T_RESET, T_ALU, T_MUL, T_DONE, T_ORDER, T_HOLD} test_e;

  string test_names [6] = '{"reset_state", "alu_results", "mul_results",
                            "completeness", "class_order", "backpressure_hold"};
  int    checks [6];
  int    errors [6];
  int    num_ops = 400;
  int    issued = 0;
  int    written = 0;
  int    operand_draws = 0;
  bit    issue_xfer_seen = 1'b0;  // Set at negedge, used by driver
  bit    hold_armed = 1'b0;
  logic [31:0] edge_vals [5] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000,
                                 32'h0000_0001, 32'h7fff_ffff};

  logic        clk = 1'b0;
  logic        rst;
  logic        issue_val;
  logic        issue_rdy;
  logic [5:0]  issue_seq_num;
  logic [31:0] issue_op1;
  logic [31:0] issue_op2;
  logic [4:0]  issue_waddr;
  exec_uop_e   issue_uop;
  logic        wb_val;
  logic        wb_rdy;
  logic [5:0]  wb_seq_num;
  logic [4:0]  wb_waddr;
  logic [31:0] wb_wdata;
  logic [5:0]  held_seq;   // wb fields seen under stall
  logic [4:0]  held_waddr;
  logic [31:0] held_wdata;

  always #4 clk = ~clk;  // Period 8

  exec_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .issue_val     (issue_val),
    .issue_rdy     (issue_rdy),
    .issue_seq_num (issue_seq_num),
    .issue_op1     (issue_op1),
    .issue_op2     (issue_op2),
    .issue_waddr   (issue_waddr),
    .issue_uop     (issue_uop),
    .wb_val        (wb_val),
    .wb_rdy        (wb_rdy),
    .wb_seq_num    (wb_seq_num),
    .wb_waddr      (wb_waddr),
    .wb_wdata      (wb_wdata)
  );

  //----------------------------------------
  // Checks
  //----------------------------------------

  task automatic check_reset_state(string when);
    checks[T_RESET]++;
    assert (wb_val === 1'b0) else begin
      $display("reset_state: wb_val was not low %s", when);
      errors[T_RESET]++;
    end
    assert (issue_rdy === 1'b1) else begin
      $display("reset_state: issue_rdy was not high %s", when);
      errors[T_RESET]++;
    end
  endtask

  task automatic check_writeback();
    logic [5:0] s;
    logic [5:0] head;
    test_e      t;
    s = wb_seq_num;
    written++;
    checks[T_DONE]++;
    assert (!$isunknown(s) && pending[s]) else begin
      $display("completeness: unknown or duplicate seq_num %0d written back", s);
      errors[T_DONE]++;
    end
    if ($isunknown(s) || !pending[s]) return;
    t = exp_is_mul[s] ? T_MUL : T_ALU;
    checks[t]++;
    assert (wb_wdata === exp_wdata[s]) else begin
      $display("FAIL %s seq=%0d wdata expected=%h actual=%h",
               test_names[t], s, exp_wdata[s], wb_wdata);
      errors[t]++;
    end
    assert (wb_waddr === exp_waddr[s]) else begin
      $display("FAIL %s seq=%0d waddr expected=%0d actual=%0d",
               test_names[t], s, exp_waddr[s], wb_waddr);
      errors[t]++;
    end
    checks[T_ORDER]++;
    head = exp_is_mul[s] ? mul_order.pop_front() : alu_order.pop_front();
    assert (head == s) else begin
      $display("FAIL class_order seq expected=%0d actual=%0d", head, s);
      errors[T_ORDER]++;
    end
    pending[s] = 1'b0;
    outstanding--;
  endtask

  task automatic check_hold();
    checks[T_HOLD]++;
    assert (wb_val === 1'b1) else begin
      $display("backpressure_hold: wb_val dropped before the transfer");
      errors[T_HOLD]++;
    end
    assert (wb_seq_num === held_seq && wb_waddr === held_waddr) else begin
      $display("FAIL backpressure_hold seq/waddr expected=%0d/%0d actual=%0d/%0d",
               held_seq, held_waddr, wb_seq_num, wb_waddr);
      errors[T_HOLD]++;
    end
    assert (wb_wdata === held_wdata) else begin
      $display("FAIL backpressure_hold wdata expected=%h actual=%h", held_wdata, wb_wdata);
      errors[T_HOLD]++;
    end
  endtask

  // Negedge monitor, handshakes settled by now
  always @(negedge clk) begin
    if (!rst) begin
      issue_xfer_seen = issue_val && issue_rdy;  // Transfer on next edge
      if (issue_xfer_seen) begin
        model_issue(issue_seq_num, issue_uop, issue_op1, issue_op2, issue_waddr);
        issued++;
      end
      if (hold_armed) check_hold();
      if (wb_val && wb_rdy) check_writeback();
      hold_armed = wb_val && !wb_rdy;
      held_seq   = wb_seq_num;
      held_waddr = wb_waddr;
      held_wdata = wb_wdata;
    end
  end

  //----------------------------------------
  // Stimulus
  //----------------------------------------

  task automatic draw_issue();
    logic [31:0] hi;
    logic [31:0] lo;
    issue_val = rand_below(10) < 7;  // About 70% busy
    if (issue_val) begin
      operand_draws++;
      issue_seq_num = issued[5:0];
      issue_uop     = exec_uop_e'(rand_below(10));
      issue_waddr   = rand_below(32);
      if (operand_draws % 5 == 0) begin
        issue_op1 = edge_vals[rand_below(5)];  // Corner operands
        issue_op2 = edge_vals[rand_below(5)];
      end else begin
        hi = lcg_next();
        lo = lcg_next();
        issue_op1 = {hi[31:16], lo[31:16]};
        hi = lcg_next();
        lo = lcg_next();
        issue_op2 = {hi[31:16], lo[31:16]};
      end
    end
  endtask

  function automatic int total_errors();
    int sum;
    sum = 0;
    foreach (errors[i]) sum += errors[i];
    return sum;
  endfunction

  task automatic report_test(test_e t);
    $display("%-18s checks=%0d errors=%0d %s", test_names[t], checks[t], errors[t],
             (errors[t] == 0) ? "ok" : "failed");
  endtask

  initial begin
    int failed;
    rst           = 1'b1;
    issue_val     = 1'b0;
    issue_seq_num = '0;
    issue_op1     = '0;
    issue_op2     = '0;
    issue_waddr   = '0;
    issue_uop     = OP_ADD;
    wb_rdy        = 1'b0;
    failed        = 0;

    @(posedge clk);
    @(negedge clk);
    check_reset_state("during reset");
    @(posedge clk);
    #1 rst = 1'b0;   // Two reset edges seen
    @(negedge clk);
    check_reset_state("right after reset");
    report_test(T_RESET);

    while (issued < num_ops) begin
      @(posedge clk);
      #1;
      if (issue_val && !issue_xfer_seen) begin
        // Not taken yet, hold the op
      end else if (issued >= num_ops) begin
        issue_val = 1'b0;
      end else begin
        draw_issue();
      end
      wb_rdy = rand_below(10) >= 3;  // About 30% stall
    end

    wb_rdy = 1'b1;  // Drain
    for (int i = 0; i < 200 && outstanding != 0; i++) @(negedge clk);
    @(negedge clk);

    checks[T_DONE]++;
    assert (outstanding == 0 && alu_order.size() == 0 && mul_order.size() == 0) else begin
      $display("completeness: %0d operations never written back", outstanding);
      errors[T_DONE]++;
    end
    assert (written == issued) else begin
      $display("FAIL completeness writebacks expected=%0d actual=%0d", issued, written);
      errors[T_DONE]++;
    end

    for (int t = T_ALU; t <= T_HOLD; t++) report_test(test_e'(t));
    foreach (errors[i]) if (errors[i] != 0) failed++;
    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors, %0d ops",
             6, 6 - failed, failed, total_errors(), issued);
    if (total_errors() == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Budget per op covers multiplier depth plus stalls
  initial begin
    #(num_ops * (mul_stages + 8) * 8);
    $display("watchdog: run did not finish in time, %0d of %0d ops issued", issued, num_ops);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verif
logic/exec_pkg.sv
logic/dx_if.sv
logic/xw_if.sv
logic/exec_issue_queue.sv
logic/exec_alu.sv
logic/exec_mul_pipe.sv
logic/exec_wb_arbiter.sv
logic/exec_top.sv
verif/exec_tb.sv
